// ==== logic/core_pkg.sv ====
// Types shared by every block of the integer core
package core_pkg;

    localparam int ARF_ID_WIDTH   = 5;   // 32 architectural registers
    localparam int REG_DATA_WIDTH = 32;
    localparam int ADDR_WIDTH     = 32;

    // Architectural register index
    typedef logic [ARF_ID_WIDTH-1:0] arf_id_t;

    // Integer register value
    typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;

    // Instruction address, used for both pc and next pc
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

// ==== logic/rob_pkg.sv ====
// Reorder buffer sizes and record layouts
package rob_pkg;

    localparam int ROB_N_ENTRIES = 8;
    localparam int ROB_ID_WIDTH  = $clog2(ROB_N_ENTRIES);

    // Entry index, also the tag handed out at dispatch
    typedef logic [ROB_ID_WIDTH-1:0] rob_id_t;

    // What fetch hands over with each instruction
    typedef struct packed {
        logic               dst_valid;   // Instruction writes a register
        core_pkg::arf_id_t  dst_arf_id;
        core_pkg::addr_t    pc;
    } rob_dispatch_data_t;

    // One stored ROB entry
    typedef struct packed {
        logic                dst_valid;
        core_pkg::arf_id_t   dst_arf_id;
        core_pkg::addr_t     pc_npc;      // pc at dispatch, next pc after ALU write-back
        logic                ld_mispred;
        logic                br_mispred;
        logic                reg_ready;   // Result can be forwarded and retired
        core_pkg::reg_data_t reg_data;
    } rob_entry_t;

endpackage

// ==== logic/rob_ram.sv ====
`timescale 1ns/1ps

// Circular entry store with FIFO enqueue/dequeue plus random access ports
module rob_ram #(
    parameter type  entry_t    = logic [7:0],
    parameter int   N_ENTRIES  = rob_pkg::ROB_N_ENTRIES,
    parameter int   N_RD_PORTS = 2,
    parameter int   N_WR_PORTS = 3,
    localparam int  AW         = $clog2(N_ENTRIES)
) (
    input  logic                                 clk,
    input  logic                                 rst_n,

    // Enqueue at the tail
    input  logic                                 enq_valid,
    output logic                                 enq_ready,
    input  entry_t                               enq_data,
    output logic [AW-1:0]                        enq_addr,

    // Dequeue from the head
    input  logic                                 deq_ready,
    output logic                                 deq_valid,
    output entry_t                               deq_data,
    output logic [AW-1:0]                        deq_addr,

    // Random read ports
    input  logic [N_RD_PORTS-1:0][AW-1:0]        rd_addr,
    output entry_t [N_RD_PORTS-1:0]              rd_data,

    // Random write ports, higher index wins on a collision
    input  logic [N_WR_PORTS-1:0]                wr_en,
    input  logic [N_WR_PORTS-1:0][AW-1:0]        wr_addr,
    input  entry_t [N_WR_PORTS-1:0]              wr_data,

    output entry_t [N_ENTRIES-1:0]               entry_douts,

    input  logic                                 flush
);
    localparam int CW = $clog2(N_ENTRIES + 1);

    entry_t               mem_q [N_ENTRIES];
    logic [N_ENTRIES-1:0] valid_q;
    logic [AW-1:0]        head_q;
    logic [AW-1:0]        tail_q;
    logic [CW-1:0]        count_q;
    logic                 enq_fire;
    logic                 deq_fire;

    // Wrap without relying on a power-of-two depth
    function automatic logic [AW-1:0] ptr_next(input logic [AW-1:0] ptr);
        if (ptr == AW'(N_ENTRIES - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign enq_ready = (count_q != CW'(N_ENTRIES));
    assign enq_addr  = tail_q;
    assign enq_fire  = enq_valid && enq_ready && !flush;   // Flush drops the new entry

    assign deq_valid = valid_q[head_q];
    assign deq_data  = mem_q[head_q];
    assign deq_addr  = head_q;
    assign deq_fire  = deq_valid && deq_ready && !flush;

    for (genvar p = 0; p < N_RD_PORTS; p++) begin : g_rd
        assign rd_data[p] = mem_q[rd_addr[p]];
    end

    for (genvar e = 0; e < N_ENTRIES; e++) begin : g_dout
        assign entry_douts[e] = mem_q[e];
    end

    // Occupancy bookkeeping
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else if (flush) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else begin
            if (enq_fire) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= ptr_next(tail_q);
            end
            if (deq_fire) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= ptr_next(head_q);
            end
            count_q <= count_q + CW'(enq_fire) - CW'(deq_fire);
        end
    end

    // Payload store, writes applied in port order so the last port lands
    always_ff @(posedge clk) begin
        for (int w = 0; w < N_WR_PORTS; w++) begin
            if (wr_en[w]) begin
                mem_q[wr_addr[w]] <= wr_data[w];
            end
        end
        if (enq_fire) begin
            mem_q[tail_q] <= enq_data;   // Tail slot is never a write-back target
        end
    end

    // Write-back units may only touch entries that are in flight
    for (genvar w = 0; w < N_WR_PORTS; w++) begin : g_wr_chk
        a_wr_live_entry: assert property (@(posedge clk) disable iff (!rst_n)
            wr_en[w] |-> valid_q[wr_addr[w]]);
    end

    // Count and valid bits must agree that the tail slot is free
    a_enq_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        enq_fire |-> !valid_q[tail_q]);

endmodule

// ==== logic/rob.sv ====
`timescale 1ns/1ps

// Reorder buffer with in-order dispatch, out-of-order completion and in-order retire
module rob (
    input  logic                        clk,
    input  logic                        rst_n,

    // Dispatch from fetch
    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    output rob_pkg::rob_id_t            dispatch_rob_id,
    input  rob_pkg::rob_dispatch_data_t dispatch_data,

    // Operand reads
    input  rob_pkg::rob_id_t            rob_id_src1,
    output logic                        rob_reg_ready_src1,
    output core_pkg::reg_data_t         rob_reg_data_src1,
    input  rob_pkg::rob_id_t            rob_id_src2,
    output logic                        rob_reg_ready_src2,
    output core_pkg::reg_data_t         rob_reg_data_src2,

    // Integer issue queue wakeup
    input  logic                        iiq_wakeup_valid,
    input  rob_pkg::rob_id_t            iiq_wakeup_rob_id,

    // ALU write-back
    input  logic                        alu_wb_valid,
    input  rob_pkg::rob_id_t            alu_wb_rob_id,
    input  core_pkg::reg_data_t         alu_wb_reg_data,
    input  logic                        alu_npc_wb_valid,
    input  logic                        alu_npc_mispred,
    input  core_pkg::addr_t             alu_npc,

    // Load write-back
    input  logic                        ld_wb_valid,
    input  rob_pkg::rob_id_t            ld_wb_rob_id,
    input  core_pkg::reg_data_t         ld_wb_reg_data,
    input  logic                        ld_wb_ld_mispred,

    input  logic                        fetch_redirect_valid,   // Empties the ROB

    // Retire towards the ARF, which never stalls
    output logic                        retire,
    output rob_pkg::rob_id_t            retire_rob_id,
    output logic                        retire_dst_valid,
    output core_pkg::arf_id_t           retire_arf_id,
    output core_pkg::reg_data_t         retire_reg_data,
    output logic                        retire_redirect_pc_valid,
    output core_pkg::addr_t             retire_redirect_pc
);
    localparam int N_RD_PORTS = 2;
    localparam int N_WR_PORTS = 3;   // Wakeup, ALU, load in rising priority

    rob_pkg::rob_entry_t [rob_pkg::ROB_N_ENTRIES-1:0] rob_state;
    rob_pkg::rob_entry_t [N_RD_PORTS-1:0]             rd_entry;
    rob_pkg::rob_entry_t [N_WR_PORTS-1:0]             wr_entry;
    rob_pkg::rob_entry_t dispatch_entry;
    rob_pkg::rob_entry_t head_entry;
    rob_pkg::rob_entry_t wakeup_entry;
    rob_pkg::rob_entry_t alu_entry;
    rob_pkg::rob_entry_t ld_entry;
    logic                head_valid;
    logic                head_mispred;
    logic                head_retirable;

    // Fresh entry starts not ready with no mispredict and zero data
    always_comb begin
        dispatch_entry            = '0;
        dispatch_entry.dst_valid  = dispatch_data.dst_valid;
        dispatch_entry.dst_arf_id = dispatch_data.dst_arf_id;
        dispatch_entry.pc_npc     = dispatch_data.pc;
    end

    // Each later port starts from the earlier port's result when the ids match,
    // so same-cycle updates merge field by field
    always_comb begin
        wakeup_entry           = rob_state[iiq_wakeup_rob_id];
        wakeup_entry.reg_ready = 1'b1;

        alu_entry = rob_state[alu_wb_rob_id];
        if (iiq_wakeup_valid && iiq_wakeup_rob_id == alu_wb_rob_id) begin
            alu_entry = wakeup_entry;
        end
        alu_entry.reg_data = alu_wb_reg_data;
        if (alu_npc_wb_valid) begin
            alu_entry.pc_npc     = alu_npc;
            alu_entry.br_mispred = alu_npc_mispred;
        end

        // Load sets ready itself so a same-cycle wakeup adds nothing
        ld_entry = rob_state[ld_wb_rob_id];
        if (alu_wb_valid && alu_wb_rob_id == ld_wb_rob_id) begin
            ld_entry = alu_entry;
        end
        ld_entry.reg_data   = ld_wb_reg_data;
        ld_entry.reg_ready  = 1'b1;
        ld_entry.ld_mispred = ld_wb_ld_mispred;
    end

    assign wr_entry = {ld_entry, alu_entry, wakeup_entry};

    rob_ram #(
        .entry_t    (rob_pkg::rob_entry_t),
        .N_ENTRIES  (rob_pkg::ROB_N_ENTRIES),
        .N_RD_PORTS (N_RD_PORTS),
        .N_WR_PORTS (N_WR_PORTS)
    ) rob_ram_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .enq_valid   (dispatch_valid),
        .enq_ready   (dispatch_ready),
        .enq_data    (dispatch_entry),
        .enq_addr    (dispatch_rob_id),
        .deq_ready   (head_retirable),
        .deq_valid   (head_valid),
        .deq_data    (head_entry),
        .deq_addr    (retire_rob_id),
        .rd_addr     ({rob_id_src2, rob_id_src1}),
        .rd_data     (rd_entry),
        .wr_en       ({ld_wb_valid, alu_wb_valid, iiq_wakeup_valid}),
        .wr_addr     ({ld_wb_rob_id, alu_wb_rob_id, iiq_wakeup_rob_id}),
        .wr_data     (wr_entry),
        .entry_douts (rob_state),
        .flush       (fetch_redirect_valid)
    );

    assign rob_reg_ready_src1 = rd_entry[0].reg_ready;
    assign rob_reg_data_src1  = rd_entry[0].reg_data;
    assign rob_reg_ready_src2 = rd_entry[1].reg_ready;
    assign rob_reg_data_src2  = rd_entry[1].reg_data;

    assign head_mispred   = head_entry.br_mispred || head_entry.ld_mispred;
    assign head_retirable = head_entry.reg_ready && !head_mispred;

    assign retire           = head_valid && head_retirable;
    assign retire_dst_valid = head_entry.dst_valid;
    assign retire_arf_id    = head_entry.dst_arf_id;
    assign retire_reg_data  = head_entry.reg_data;

    // A mispredicted head blocks retirement and holds the redirect until flushed
    assign retire_redirect_pc_valid = head_valid && head_entry.reg_ready && head_mispred;
    assign retire_redirect_pc       = head_entry.pc_npc;

    // ALU and load unit never complete the same instruction
    a_alu_ld_distinct: assert property (@(posedge clk) disable iff (!rst_n)
        alu_wb_valid && ld_wb_valid |-> alu_wb_rob_id != ld_wb_rob_id);

endmodule

// ==== logic/arf.sv ====
`timescale 1ns/1ps

// Architectural register file, written only at retirement
module arf #(
    parameter int N_REGS = 32
) (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                wr_en,
    input  core_pkg::arf_id_t   wr_id,
    input  core_pkg::reg_data_t wr_data,

    input  core_pkg::arf_id_t   rd_id_src1,
    output core_pkg::reg_data_t rd_data_src1,
    input  core_pkg::arf_id_t   rd_id_src2,
    output core_pkg::reg_data_t rd_data_src2
);
    core_pkg::reg_data_t regs_q [N_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < N_REGS; r++) begin
                regs_q[r] <= '0;
            end
        end else if (wr_en && wr_id != '0) begin   // r0 stays zero
            regs_q[wr_id] <= wr_data;
        end
    end

    assign rd_data_src1 = regs_q[rd_id_src1];
    assign rd_data_src2 = regs_q[rd_id_src2];

    // Retirement logic already filters out r0 destinations
    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en |-> wr_id != '0);

endmodule

// ==== logic/rob_subsystem.sv ====
`timescale 1ns/1ps

// ROB plus ARF, retirement feeds the register file write port
module rob_subsystem #(
    parameter int ARF_N_REGS = 32
) (
    input  logic                        clk,
    input  logic                        rst_n,

    input  logic                        dispatch_valid,
    output logic                        dispatch_ready,
    output rob_pkg::rob_id_t            dispatch_rob_id,
    input  rob_pkg::rob_dispatch_data_t dispatch_data,

    input  rob_pkg::rob_id_t            rob_id_src1,
    output logic                        rob_reg_ready_src1,
    output core_pkg::reg_data_t         rob_reg_data_src1,
    input  rob_pkg::rob_id_t            rob_id_src2,
    output logic                        rob_reg_ready_src2,
    output core_pkg::reg_data_t         rob_reg_data_src2,

    input  logic                        iiq_wakeup_valid,
    input  rob_pkg::rob_id_t            iiq_wakeup_rob_id,

    input  logic                        alu_wb_valid,
    input  rob_pkg::rob_id_t            alu_wb_rob_id,
    input  core_pkg::reg_data_t         alu_wb_reg_data,
    input  logic                        alu_npc_wb_valid,
    input  logic                        alu_npc_mispred,
    input  core_pkg::addr_t             alu_npc,

    input  logic                        ld_wb_valid,
    input  rob_pkg::rob_id_t            ld_wb_rob_id,
    input  core_pkg::reg_data_t         ld_wb_reg_data,
    input  logic                        ld_wb_ld_mispred,

    input  logic                        fetch_redirect_valid,

    output logic                        retire,
    output rob_pkg::rob_id_t            retire_rob_id,
    output core_pkg::arf_id_t           retire_arf_id,
    output core_pkg::reg_data_t         retire_reg_data,
    output logic                        retire_redirect_pc_valid,
    output core_pkg::addr_t             retire_redirect_pc,

    // Architectural register reads
    input  core_pkg::arf_id_t           arf_rd_id_src1,
    output core_pkg::reg_data_t         arf_rd_data_src1,
    input  core_pkg::arf_id_t           arf_rd_id_src2,
    output core_pkg::reg_data_t         arf_rd_data_src2
);
    logic retire_dst_valid;
    logic arf_wr_en;

    rob rob_i (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .dispatch_valid           (dispatch_valid),
        .dispatch_ready           (dispatch_ready),
        .dispatch_rob_id          (dispatch_rob_id),
        .dispatch_data            (dispatch_data),
        .rob_id_src1              (rob_id_src1),
        .rob_reg_ready_src1       (rob_reg_ready_src1),
        .rob_reg_data_src1        (rob_reg_data_src1),
        .rob_id_src2              (rob_id_src2),
        .rob_reg_ready_src2       (rob_reg_ready_src2),
        .rob_reg_data_src2        (rob_reg_data_src2),
        .iiq_wakeup_valid         (iiq_wakeup_valid),
        .iiq_wakeup_rob_id        (iiq_wakeup_rob_id),
        .alu_wb_valid             (alu_wb_valid),
        .alu_wb_rob_id            (alu_wb_rob_id),
        .alu_wb_reg_data          (alu_wb_reg_data),
        .alu_npc_wb_valid         (alu_npc_wb_valid),
        .alu_npc_mispred          (alu_npc_mispred),
        .alu_npc                  (alu_npc),
        .ld_wb_valid              (ld_wb_valid),
        .ld_wb_rob_id             (ld_wb_rob_id),
        .ld_wb_reg_data           (ld_wb_reg_data),
        .ld_wb_ld_mispred         (ld_wb_ld_mispred),
        .fetch_redirect_valid     (fetch_redirect_valid),
        .retire                   (retire),
        .retire_rob_id            (retire_rob_id),
        .retire_dst_valid         (retire_dst_valid),
        .retire_arf_id            (retire_arf_id),
        .retire_reg_data          (retire_reg_data),
        .retire_redirect_pc_valid (retire_redirect_pc_valid),
        .retire_redirect_pc       (retire_redirect_pc)
    );

    // Instructions targeting r0 retire without touching the ARF
    assign arf_wr_en = retire && retire_dst_valid && (retire_arf_id != '0);

    arf #(
        .N_REGS (ARF_N_REGS)
    ) arf_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (arf_wr_en),
        .wr_id        (retire_arf_id),
        .wr_data      (retire_reg_data),
        .rd_id_src1   (arf_rd_id_src1),
        .rd_data_src1 (arf_rd_data_src1),
        .rd_id_src2   (arf_rd_id_src2),
        .rd_data_src2 (arf_rd_data_src2)
    );

endmodule

// ==== verification/tb_rob_subsystem.sv ====
`timescale 1ns/1ps

// Trace-driven testbench for the ROB plus ARF subsystem
module tb_rob_subsystem;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int N_FIELDS       = 5;

    logic                        clk;
    logic                        rst_n;
    logic                        dispatch_valid;
    logic                        dispatch_ready;
    rob_pkg::rob_id_t            dispatch_rob_id;
    rob_pkg::rob_dispatch_data_t dispatch_data;
    rob_pkg::rob_id_t            rob_id_src1;
    logic                        rob_reg_ready_src1;
    core_pkg::reg_data_t         rob_reg_data_src1;
    rob_pkg::rob_id_t            rob_id_src2;
    logic                        rob_reg_ready_src2;
    core_pkg::reg_data_t         rob_reg_data_src2;
    logic                        iiq_wakeup_valid;
    rob_pkg::rob_id_t            iiq_wakeup_rob_id;
    logic                        alu_wb_valid;
    rob_pkg::rob_id_t            alu_wb_rob_id;
    core_pkg::reg_data_t         alu_wb_reg_data;
    logic                        alu_npc_wb_valid;
    logic                        alu_npc_mispred;
    core_pkg::addr_t             alu_npc;
    logic                        ld_wb_valid;
    rob_pkg::rob_id_t            ld_wb_rob_id;
    core_pkg::reg_data_t         ld_wb_reg_data;
    logic                        ld_wb_ld_mispred;
    logic                        fetch_redirect_valid;
    logic                        retire;
    rob_pkg::rob_id_t            retire_rob_id;
    core_pkg::arf_id_t           retire_arf_id;
    core_pkg::reg_data_t         retire_reg_data;
    logic                        retire_redirect_pc_valid;
    core_pkg::addr_t             retire_redirect_pc;
    core_pkg::arf_id_t           arf_rd_id_src1;
    core_pkg::reg_data_t         arf_rd_data_src1;
    core_pkg::arf_id_t           arf_rd_id_src2;
    core_pkg::reg_data_t         arf_rd_data_src2;

    // Retirements in the order the DUT reported them
    rob_pkg::rob_id_t    retired_ids  [$];
    core_pkg::arf_id_t   retired_arfs [$];
    core_pkg::reg_data_t retired_data [$];

    int           fd;
    logic [127:0] cmd;            // Command word of the current trace line
    logic [31:0]  f [N_FIELDS];   // Its hex fields

    rob_subsystem dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Retire pulses last one cycle and are all collected here
    always @(negedge clk) begin
        if (rst_n && retire) begin
            retired_ids.push_back(retire_rob_id);
            retired_arfs.push_back(retire_arf_id);
            retired_data.push_back(retire_reg_data);
        end
    end

    task automatic stop_on_error();
        $display("Some tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_id(input string name, input rob_pkg::rob_id_t got,
                            input rob_pkg::rob_id_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_arf_id(input string name, input core_pkg::arf_id_t got,
                                input core_pkg::arf_id_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_data(input string name, input core_pkg::reg_data_t got,
                              input core_pkg::reg_data_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input core_pkg::addr_t got,
                              input core_pkg::addr_t exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic count_wait(inout int waited, input string what);
        if (waited == TIMEOUT_CYCLES) begin
            $display("timeout while waiting for %s", what);
            stop_on_error();
        end
        waited++;
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic end_strobe();
        step();
        iiq_wakeup_valid     = 1'b0;
        alu_wb_valid         = 1'b0;
        alu_npc_wb_valid     = 1'b0;
        ld_wb_valid          = 1'b0;
        fetch_redirect_valid = 1'b0;
    endtask

    task automatic read_fields(input int cnt);
        for (int i = 0; i < cnt; i++) begin
            if ($fscanf(fd, "%h", f[i]) != 1) begin
                $display("trace line for %0s is missing fields", cmd);
                stop_on_error();
            end
        end
    endtask

    task automatic run_command();
        logic [8*160-1:0] line;
        int               waited;

        waited = 0;
        case (cmd)
            128'("#"): begin
                void'($fgets(line, fd));   // Rest of a comment line
            end
            128'("disp"): begin
                read_fields(4);
                step();
                dispatch_valid           = 1'b1;
                dispatch_data.dst_valid  = f[0][0];
                dispatch_data.dst_arf_id = core_pkg::arf_id_t'(f[1]);
                dispatch_data.pc         = f[2];
                @(negedge clk);
                while (!dispatch_ready) begin   // Request held while the ROB is full
                    count_wait(waited, "dispatch_ready");
                    @(negedge clk);
                end
                check_id("dispatch_rob_id", dispatch_rob_id, rob_pkg::rob_id_t'(f[3]));
                step();
                dispatch_valid = 1'b0;
            end
            128'("ready"): begin
                read_fields(1);
                @(negedge clk);
                check_bit("dispatch_ready", dispatch_ready, f[0][0]);
            end
            128'("opnd"): begin
                read_fields(3);
                step();
                rob_id_src1 = rob_pkg::rob_id_t'(f[0]);
                rob_id_src2 = ~rob_pkg::rob_id_t'(f[0]);   // Other port on another entry
                @(negedge clk);
                check_bit("rob_reg_ready_src1", rob_reg_ready_src1, f[1][0]);
                check_data("rob_reg_data_src1", rob_reg_data_src1, f[2]);
                step();
                rob_id_src1 = ~rob_pkg::rob_id_t'(f[0]);
                rob_id_src2 = rob_pkg::rob_id_t'(f[0]);
                @(negedge clk);
                check_bit("rob_reg_ready_src2", rob_reg_ready_src2, f[1][0]);
                check_data("rob_reg_data_src2", rob_reg_data_src2, f[2]);
            end
            128'("wake"): begin
                read_fields(1);
                step();
                iiq_wakeup_valid  = 1'b1;
                iiq_wakeup_rob_id = rob_pkg::rob_id_t'(f[0]);
                end_strobe();
            end
            128'("alu"): begin
                read_fields(5);
                step();
                alu_wb_valid     = 1'b1;
                alu_wb_rob_id    = rob_pkg::rob_id_t'(f[0]);
                alu_wb_reg_data  = f[1];
                alu_npc_wb_valid = f[2][0];
                alu_npc_mispred  = f[3][0];
                alu_npc          = f[4];
                end_strobe();
            end
            128'("load"): begin
                read_fields(3);
                step();
                ld_wb_valid      = 1'b1;
                ld_wb_rob_id     = rob_pkg::rob_id_t'(f[0]);
                ld_wb_reg_data   = f[1];
                ld_wb_ld_mispred = f[2][0];
                end_strobe();
            end
            128'("wakeload"): begin
                read_fields(2);
                step();
                iiq_wakeup_valid  = 1'b1;
                iiq_wakeup_rob_id = rob_pkg::rob_id_t'(f[0]);
                ld_wb_valid       = 1'b1;
                ld_wb_rob_id      = rob_pkg::rob_id_t'(f[0]);
                ld_wb_reg_data    = f[1];
                ld_wb_ld_mispred  = 1'b0;
                end_strobe();
            end
            128'("flush"): begin
                step();
                fetch_redirect_valid = 1'b1;
                end_strobe();
            end
            128'("retire"): begin
                read_fields(3);
                while (retired_ids.size() == 0) begin
                    count_wait(waited, "a retire pulse");
                    @(posedge clk);
                end
                check_id("retire_rob_id", retired_ids.pop_front(), rob_pkg::rob_id_t'(f[0]));
                check_arf_id("retire_arf_id", retired_arfs.pop_front(),
                             core_pkg::arf_id_t'(f[1]));
                check_data("retire_reg_data", retired_data.pop_front(), f[2]);
            end
            128'("redir"): begin
                read_fields(1);
                @(negedge clk);
                while (!retire_redirect_pc_valid) begin
                    count_wait(waited, "retire_redirect_pc_valid");
                    @(negedge clk);
                end
                check_addr("retire_redirect_pc", retire_redirect_pc, f[0]);
                check_bit("retire", retire, 1'b0);   // Mispredicted head never retires
            end
            128'("arf"): begin
                read_fields(2);
                step();
                arf_rd_id_src1 = core_pkg::arf_id_t'(f[0]);
                arf_rd_id_src2 = '0;   // r0 always reads zero
                @(negedge clk);
                check_data("arf_rd_data_src1", arf_rd_data_src1, f[1]);
                check_data("arf_rd_data_src2", arf_rd_data_src2, '0);
                step();
                arf_rd_id_src1 = '0;
                arf_rd_id_src2 = core_pkg::arf_id_t'(f[0]);
                @(negedge clk);
                check_data("arf_rd_data_src1", arf_rd_data_src1, '0);
                check_data("arf_rd_data_src2", arf_rd_data_src2, f[1]);
            end
            default: begin
                $display("unknown trace command %0s", cmd);
                stop_on_error();
            end
        endcase
    endtask

    initial begin
        int   n;
        logic trace_done;

        rst_n                = 1'b0;
        dispatch_valid       = 1'b0;
        dispatch_data        = '0;
        rob_id_src1          = '0;
        rob_id_src2          = '0;
        iiq_wakeup_valid     = 1'b0;
        iiq_wakeup_rob_id    = '0;
        alu_wb_valid         = 1'b0;
        alu_wb_rob_id        = '0;
        alu_wb_reg_data      = '0;
        alu_npc_wb_valid     = 1'b0;
        alu_npc_mispred      = 1'b0;
        alu_npc              = '0;
        ld_wb_valid          = 1'b0;
        ld_wb_rob_id         = '0;
        ld_wb_reg_data       = '0;
        ld_wb_ld_mispred     = 1'b0;
        fetch_redirect_valid = 1'b0;
        arf_rd_id_src1       = '0;
        arf_rd_id_src2       = '0;
        void'($urandom(20172));

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_bit("retire", retire, 1'b0);
        check_bit("retire_redirect_pc_valid", retire_redirect_pc_valid, 1'b0);
        check_bit("dispatch_ready", dispatch_ready, 1'b1);

        fd = $fopen("verification/rob_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file verification/rob_trace.txt");
            stop_on_error();
        end
        trace_done = 1'b0;
        while (!trace_done) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                trace_done = 1'b1;
            end else begin
                run_command();
                repeat ($urandom_range(2, 0)) step();   // Random idle gap
            end
        end
        $fclose(fd);

        if (retired_ids.size() != 0) begin
            $display("%0d retire pulses were not expected by the trace", retired_ids.size());
            stop_on_error();
        end else begin
            $display("All tests passed");
            $finish;
        end
    end

endmodule

// ==== verification/rob_trace.txt ====
# Each line is a command with hex fields, lines starting with # are comments
# disp dst_valid arf pc exp_id | ready r | opnd id rdy data | wake id | alu id data npcv mis npc
# load id data mis | wakeload id data | flush | retire id arf data | redir pc | arf id data
ready 1
arf 01 00000000
# Fill the ROB, ids start at 0
disp 1 01 00001000 0
disp 1 02 00001004 1
disp 1 00 00001008 2
disp 1 03 0000100c 3
disp 0 00 00001010 4
disp 1 04 00001014 5
disp 1 05 00001018 6
disp 1 06 0000101c 7
ready 0
opnd 3 0 00000000
alu 3 00000033 0 0 00000000
wake 3
opnd 3 1 00000033
load 1 11111111 0
opnd 1 1 11111111
alu 2 deadbeef 0 0 00000000
wake 2
ready 0
# Completing the head releases entries 0 to 3 in order
alu 0 000000aa 0 0 00000000
wake 0
retire 0 01 000000aa
ready 1
retire 1 02 11111111
retire 2 00 deadbeef
retire 3 03 00000033
arf 01 000000aa
arf 02 11111111
arf 00 00000000
arf 03 00000033
# Correct branch retires, mispredicted branch redirects to its next pc
alu 4 00000044 1 0 00001234
wake 4
retire 4 00 00000044
wake 6
alu 5 00000055 1 1 00002000
wake 5
redir 00002000
flush
# Load mispredict redirects to the dispatched pc
disp 1 07 00003000 0
disp 1 08 00003004 1
opnd 0 0 00000000
wakeload 1 0000beef
opnd 1 1 0000beef
load 0 12345678 1
redir 00003000
flush
disp 1 09 00004000 0
load 0 00000099 0
retire 0 09 00000099
arf 09 00000099

// ==== vlog.f ====
logic/core_pkg.sv
logic/rob_pkg.sv
logic/rob_ram.sv
logic/rob.sv
logic/arf.sv
logic/rob_subsystem.sv
verification/tb_rob_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the ROB subsystem testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_rob_subsystem \
    -Mdir obj_dir -o sim_rob \
    && ./obj_dir/sim_rob > sim.log 2>&1 \
    || echo "simulation build or run ended with an error"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
